// File: rtl/axi2apb_pkg.sv
/* Shared widths, vector types, structs and response codes of the AXI-to-APB bridge.
   Each bridge module imports this package in its header. */
package axi2apb_pkg;

    // ----------------------------------------------------------------------
    // Widths and codes
    // ----------------------------------------------------------------------
    localparam int ID_WIDTH       = 4;
    localparam int AXI_ADDR_WIDTH = 32;
    localparam int APB_ADDR_WIDTH = 12;
    localparam int AXI_DATA_WIDTH = 64;
    localparam int APB_DATA_WIDTH = 32;

    typedef logic [ID_WIDTH-1:0]         axi_id_t;
    typedef logic [AXI_ADDR_WIDTH-1:0]   axi_addr_t;
    typedef logic [APB_ADDR_WIDTH-1:0]   apb_addr_t;
    typedef logic [AXI_DATA_WIDTH-1:0]   axi_data_t;
    typedef logic [APB_DATA_WIDTH-1:0]   apb_data_t;
    typedef logic [AXI_DATA_WIDTH/8-1:0] axi_strb_t;
    typedef logic [2:0]                  axi_size_t;
    typedef logic [1:0]                  axi_resp_t;

    localparam axi_size_t SIZE_DWORD  = 3'd3;   // 8 bytes, split into two words
    localparam axi_resp_t RESP_OKAY   = 2'b00;
    localparam axi_resp_t RESP_SLVERR = 2'b10;

    // ----------------------------------------------------------------------
    // Bundles between the blocks
    // ----------------------------------------------------------------------
    typedef struct packed {
        logic      write;   // Set for AW+W, clear for AR
        axi_id_t   id;
        axi_addr_t addr;
        axi_size_t size;
        axi_data_t wdata;
        axi_strb_t wstrb;
    } axi_req_t;

    typedef struct packed {
        logic      write;
        apb_addr_t addr;    // Word address on the APB side
        apb_data_t wdata;
    } apb_cmd_t;

    typedef struct packed {
        apb_data_t rdata;
        logic      slverr;
    } apb_rsp_t;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_LO,
        ST_HI,
        ST_RESP
    } bridge_state_t;

endpackage

// File: rtl/axi_req_latch.sv
/* Accepts one AXI read or write request and holds it until its response is taken.
   Reads win over writes; AW and W are only taken together. */
`timescale 1ns/1ps

module axi_req_latch import axi2apb_pkg::*; (
    input  logic      ACLK,
    input  logic      ARESETn,

    input  logic      ar_valid_i,
    input  axi_id_t   ar_id_i,
    input  axi_addr_t ar_addr_i,
    input  axi_size_t ar_size_i,
    output logic      ar_ready_o,

    input  logic      aw_valid_i,
    input  axi_id_t   aw_id_i,
    input  axi_addr_t aw_addr_i,
    input  axi_size_t aw_size_i,
    output logic      aw_ready_o,

    input  logic      w_valid_i,
    input  axi_data_t w_data_i,
    input  axi_strb_t w_strb_i,
    output logic      w_ready_o,

    output axi_req_t  req_o,
    output logic      req_valid_o,
    input  logic      req_done_i
);

    logic     full_q;
    axi_req_t req_q;
    logic     rd_take;
    logic     wr_take;

    // Read has priority whenever the latch is empty
    assign ar_ready_o = !full_q;
    assign aw_ready_o = !full_q && !ar_valid_i && w_valid_i;
    assign w_ready_o  = !full_q && !ar_valid_i && aw_valid_i;

    assign rd_take = ar_valid_i && ar_ready_o;
    assign wr_take = aw_valid_i && aw_ready_o;  // W handshakes in the same cycle

    always_ff @(posedge ACLK or negedge ARESETn) begin
        if (!ARESETn) begin
            full_q <= 1'b0;
        end else if (rd_take || wr_take) begin
            full_q <= 1'b1;
        end else if (req_done_i) begin
            full_q <= 1'b0;
        end
    end

    always_ff @(posedge ACLK) begin
        if (rd_take) begin
            req_q <= '{write: 1'b0, id: ar_id_i, addr: ar_addr_i, size: ar_size_i,
                       wdata: '0, wstrb: '0};
        end else if (wr_take) begin
            req_q <= '{write: 1'b1, id: aw_id_i, addr: aw_addr_i, size: aw_size_i,
                       wdata: w_data_i, wstrb: w_strb_i};
        end
    end

    assign req_o       = req_q;
    assign req_valid_o = full_q;

endmodule

// File: rtl/bridge_ctrl.sv
/* Bridge controller FSM: plans the APB word transfers of the held request
   and returns the AXI read or write response once they are done. */
`timescale 1ns/1ps

module bridge_ctrl import axi2apb_pkg::*; (
    input  logic      ACLK,
    input  logic      ARESETn,

    input  axi_req_t  req_i,
    input  logic      req_valid_i,
    output logic      req_done_o,

    output apb_cmd_t  cmd_o,
    output logic      cmd_valid_o,
    input  logic      cmd_ready_i,
    input  logic      rsp_valid_i,
    input  logic      slverr_seen_i,

    output logic      hi_lane_o,
    output logic      clear_o,

    output logic      r_valid_o,
    input  logic      r_ready_i,
    output logic      b_valid_o,
    input  logic      b_ready_i,
    output axi_resp_t resp_o,
    output axi_id_t   id_o
);

    localparam int WORD_BYTES = APB_DATA_WIDTH / 8;

    bridge_state_t state_q;
    bridge_state_t state_d;
    logic          issued_q;    // Command out, waiting for its APB response
    logic          dword;
    logic          lo_sel;
    logic          hi_sel;
    logic          need_lo;
    logic          need_hi;
    logic          resp_done;

    // ----------------------------------------------------------------------
    // Word planning
    // ----------------------------------------------------------------------
    assign dword  = (req_i.size == SIZE_DWORD);
    assign lo_sel = dword || !req_i.addr[2];
    assign hi_sel = dword || req_i.addr[2];

    // A write half without any strobe is skipped
    assign need_lo = lo_sel && (!req_i.write || (|req_i.wstrb[WORD_BYTES-1:0]));
    assign need_hi = hi_sel &&
                     (!req_i.write || (|req_i.wstrb[2*WORD_BYTES-1:WORD_BYTES]));

    assign hi_lane_o = (state_q == ST_HI);

    // Aligned word address, bit 2 follows the lane in flight
    assign cmd_o.write = req_i.write;
    assign cmd_o.addr  = {req_i.addr[APB_ADDR_WIDTH-1:3], hi_lane_o, 2'b00};
    assign cmd_o.wdata = hi_lane_o ? req_i.wdata[AXI_DATA_WIDTH-1:APB_DATA_WIDTH]
                                   : req_i.wdata[APB_DATA_WIDTH-1:0];

    assign cmd_valid_o = ((state_q == ST_LO) || (state_q == ST_HI)) && !issued_q;

    // ----------------------------------------------------------------------
    // Response side
    // ----------------------------------------------------------------------
    assign r_valid_o = (state_q == ST_RESP) && !req_i.write;
    assign b_valid_o = (state_q == ST_RESP) && req_i.write;
    assign resp_o    = slverr_seen_i ? RESP_SLVERR : RESP_OKAY;
    assign id_o      = req_i.id;
    assign resp_done = (r_valid_o && r_ready_i) || (b_valid_o && b_ready_i);

    always_comb begin
        state_d    = state_q;
        clear_o    = 1'b0;
        req_done_o = 1'b0;
        case (state_q)
            ST_IDLE: begin
                if (req_valid_i) begin
                    clear_o = 1'b1;             // Fresh data and error flag
                    if (need_lo) begin
                        state_d = ST_LO;
                    end else if (need_hi) begin
                        state_d = ST_HI;
                    end else begin
                        state_d = ST_RESP;      // Nothing to write, plain OKAY
                    end
                end
            end
            ST_LO: begin
                if (rsp_valid_i) begin
                    state_d = need_hi ? ST_HI : ST_RESP;
                end
            end
            ST_HI: begin
                if (rsp_valid_i) begin
                    state_d = ST_RESP;
                end
            end
            ST_RESP: begin
                if (resp_done) begin
                    req_done_o = 1'b1;          // Frees the request latch
                    state_d    = ST_IDLE;
                end
            end
            default: begin
                state_d = ST_IDLE;
            end
        endcase
    end

    always_ff @(posedge ACLK or negedge ARESETn) begin
        if (!ARESETn) begin
            state_q  <= ST_IDLE;
            issued_q <= 1'b0;
        end else begin
            state_q <= state_d;
            if (rsp_valid_i) begin
                issued_q <= 1'b0;
            end else if (cmd_valid_o && cmd_ready_i) begin
                issued_q <= 1'b1;
            end
        end
    end

endmodule

// File: rtl/apb_port.sv
/* APB3 master for one 32-bit word command at a time.
   Runs setup and access phases and pulses a response when PREADY ends the access. */
`timescale 1ns/1ps

module apb_port import axi2apb_pkg::*; (
    input  logic      ACLK,
    input  logic      ARESETn,

    input  apb_cmd_t  cmd_i,
    input  logic      cmd_valid_i,
    output logic      cmd_ready_o,
    output apb_rsp_t  rsp_o,
    output logic      rsp_valid_o,

    output logic      psel_o,
    output logic      penable_o,
    output logic      pwrite_o,
    output apb_addr_t paddr_o,
    output apb_data_t pwdata_o,
    input  apb_data_t prdata_i,
    input  logic      pready_i,
    input  logic      pslverr_i
);

    apb_cmd_t cmd_q;
    logic     psel_q;
    logic     penable_q;
    logic     done;

    assign cmd_ready_o = !psel_q;               // Idle only
    assign done        = penable_q && pready_i; // PREADY counts in access phase only

    always_ff @(posedge ACLK or negedge ARESETn) begin
        if (!ARESETn) begin
            psel_q    <= 1'b0;
            penable_q <= 1'b0;
        end else if (done) begin
            psel_q    <= 1'b0;
            penable_q <= 1'b0;
        end else if (psel_q) begin
            penable_q <= 1'b1;                  // Setup to access
        end else if (cmd_valid_i) begin
            psel_q <= 1'b1;
        end
    end

    always_ff @(posedge ACLK) begin
        if (cmd_valid_i && cmd_ready_o) begin
            cmd_q <= cmd_i;
        end
    end

    assign psel_o    = psel_q;
    assign penable_o = penable_q;
    assign pwrite_o  = cmd_q.write;
    assign paddr_o   = cmd_q.addr;
    assign pwdata_o  = cmd_q.wdata;

    assign rsp_valid_o  = done;
    assign rsp_o.rdata  = prdata_i;
    assign rsp_o.slverr = pslverr_i;

endmodule

// File: rtl/rdata_collect.sv
/* Assembles APB read words into the 64-bit AXI read data
   and keeps a sticky slave error flag for the current request. */
`timescale 1ns/1ps

module rdata_collect import axi2apb_pkg::*; (
    input  logic      ACLK,
    input  logic      ARESETn,

    input  logic      clear_i,
    input  logic      rsp_valid_i,
    input  apb_rsp_t  rsp_i,
    input  logic      hi_lane_i,

    output axi_data_t rdata_o,
    output logic      slverr_o
);

    apb_data_t lo_q;
    apb_data_t hi_q;
    logic      err_q;

    // Lanes not read stay zero
    always_ff @(posedge ACLK) begin
        if (clear_i) begin
            lo_q <= '0;
            hi_q <= '0;
        end else if (rsp_valid_i) begin
            if (hi_lane_i) hi_q <= rsp_i.rdata;
            else           lo_q <= rsp_i.rdata;
        end
    end

    always_ff @(posedge ACLK or negedge ARESETn) begin
        if (!ARESETn) begin
            err_q <= 1'b0;
        end else if (clear_i) begin
            err_q <= 1'b0;
        end else if (rsp_valid_i && rsp_i.slverr) begin
            err_q <= 1'b1;                      // Any error spoils the whole request
        end
    end

    assign rdata_o  = {hi_q, lo_q};
    assign slverr_o = err_q;

endmodule

// File: rtl/axi2apb_top.sv
/* Top level of the AXI4 (64-bit, single transfer) to APB3 (32-bit) bridge.
   Connects the request latch, controller, APB port and read data collector. */
`timescale 1ns/1ps

module axi2apb_top import axi2apb_pkg::*; (
    input  logic      ACLK,
    input  logic      ARESETn,

    // ----------------------------------------------------------------------
    // AXI slave side
    // ----------------------------------------------------------------------
    input  logic      ar_valid_i,
    input  axi_id_t   ar_id_i,
    input  axi_addr_t ar_addr_i,
    input  axi_size_t ar_size_i,
    output logic      ar_ready_o,

    input  logic      aw_valid_i,
    input  axi_id_t   aw_id_i,
    input  axi_addr_t aw_addr_i,
    input  axi_size_t aw_size_i,
    output logic      aw_ready_o,

    input  logic      w_valid_i,
    input  axi_data_t w_data_i,
    input  axi_strb_t w_strb_i,
    output logic      w_ready_o,

    output axi_id_t   r_id_o,
    output axi_data_t r_data_o,
    output axi_resp_t r_resp_o,
    output logic      r_valid_o,
    input  logic      r_ready_i,

    output axi_id_t   b_id_o,
    output axi_resp_t b_resp_o,
    output logic      b_valid_o,
    input  logic      b_ready_i,

    // ----------------------------------------------------------------------
    // APB master side
    // ----------------------------------------------------------------------
    output logic      psel_o,
    output logic      penable_o,
    output logic      pwrite_o,
    output apb_addr_t paddr_o,
    output apb_data_t pwdata_o,
    input  apb_data_t prdata_i,
    input  logic      pready_i,
    input  logic      pslverr_i
);

    axi_req_t  req;
    logic      req_valid;
    logic      req_done;
    apb_cmd_t  cmd;
    logic      cmd_valid;
    logic      cmd_ready;
    apb_rsp_t  rsp;
    logic      rsp_valid;
    logic      slverr_seen;
    logic      hi_lane;
    logic      clear;
    axi_resp_t resp;
    axi_id_t   id;

    axi_req_latch u_req_latch (
        .ACLK        (ACLK),
        .ARESETn     (ARESETn),
        .ar_valid_i  (ar_valid_i),
        .ar_id_i     (ar_id_i),
        .ar_addr_i   (ar_addr_i),
        .ar_size_i   (ar_size_i),
        .ar_ready_o  (ar_ready_o),
        .aw_valid_i  (aw_valid_i),
        .aw_id_i     (aw_id_i),
        .aw_addr_i   (aw_addr_i),
        .aw_size_i   (aw_size_i),
        .aw_ready_o  (aw_ready_o),
        .w_valid_i   (w_valid_i),
        .w_data_i    (w_data_i),
        .w_strb_i    (w_strb_i),
        .w_ready_o   (w_ready_o),
        .req_o       (req),
        .req_valid_o (req_valid),
        .req_done_i  (req_done)
    );

    bridge_ctrl u_ctrl (
        .ACLK          (ACLK),
        .ARESETn       (ARESETn),
        .req_i         (req),
        .req_valid_i   (req_valid),
        .req_done_o    (req_done),
        .cmd_o         (cmd),
        .cmd_valid_o   (cmd_valid),
        .cmd_ready_i   (cmd_ready),
        .rsp_valid_i   (rsp_valid),
        .slverr_seen_i (slverr_seen),
        .hi_lane_o     (hi_lane),
        .clear_o       (clear),
        .r_valid_o     (r_valid_o),
        .r_ready_i     (r_ready_i),
        .b_valid_o     (b_valid_o),
        .b_ready_i     (b_ready_i),
        .resp_o        (resp),
        .id_o          (id)
    );

    apb_port u_apb_port (
        .ACLK        (ACLK),
        .ARESETn     (ARESETn),
        .cmd_i       (cmd),
        .cmd_valid_i (cmd_valid),
        .cmd_ready_o (cmd_ready),
        .rsp_o       (rsp),
        .rsp_valid_o (rsp_valid),
        .psel_o      (psel_o),
        .penable_o   (penable_o),
        .pwrite_o    (pwrite_o),
        .paddr_o     (paddr_o),
        .pwdata_o    (pwdata_o),
        .prdata_i    (prdata_i),
        .pready_i    (pready_i),
        .pslverr_i   (pslverr_i)
    );

    rdata_collect u_rdata (
        .ACLK        (ACLK),
        .ARESETn     (ARESETn),
        .clear_i     (clear),
        .rsp_valid_i (rsp_valid),
        .rsp_i       (rsp),
        .hi_lane_i   (hi_lane),
        .rdata_o     (r_data_o),
        .slverr_o    (slverr_seen)
    );

    // One held request, so R and B share the ID and response
    assign r_id_o   = id;
    assign r_resp_o = resp;
    assign b_id_o   = id;
    assign b_resp_o = resp;

endmodule

// File: tests/tb_clock.sv
/* Free running testbench clock, 8 ns period */
`timescale 1ns/1ps

module tb_clock (
    output logic clk_o
);

    initial clk_o = 1'b0;

    always #4 clk_o = ~clk_o;

endmodule

// File: tests/axi2apb_assertions.sv
/* Concurrent APB phase checks and two valid-held-until-ready checks for the bridge.
   Bound into apb_port and axi2apb_top by the bind lines at the end. */
`timescale 1ns/1ps

module axi2apb_assertions import axi2apb_pkg::*; (
    input logic      ACLK,
    input logic      ARESETn,
    input logic      psel,
    input logic      penable,
    input logic      pwrite,
    input apb_addr_t paddr,
    input apb_data_t pwdata,
    input logic      pready,
    input logic      valid_a,
    input logic      ready_a,
    input logic      valid_b,
    input logic      ready_b
);

    a_enable_needs_sel: assert property (@(posedge ACLK) disable iff (!ARESETn)
        penable |-> psel) else $error("PENABLE high without PSEL");

    a_sel_then_enable: assert property (@(posedge ACLK) disable iff (!ARESETn)
        $rose(psel) |=> penable) else $error("PENABLE missing after setup phase");

    // PSEL must have risen exactly one cycle earlier
    a_enable_after_setup: assert property (@(posedge ACLK) disable iff (!ARESETn)
        $rose(penable) |-> $past(psel) && !$past(psel, 2))
        else $error("PENABLE rose without a setup phase");

    a_apb_stable: assert property (@(posedge ACLK) disable iff (!ARESETn)
        (penable && !pready) |=> $stable({psel, penable, pwrite, paddr, pwdata}))
        else $error("APB signals changed during wait states");

    // Valid stays up until its ready
    a_valid_a_held: assert property (@(posedge ACLK) disable iff (!ARESETn)
        (valid_a && !ready_a) |=> valid_a) else $error("First valid dropped before its ready");

    a_valid_b_held: assert property (@(posedge ACLK) disable iff (!ARESETn)
        (valid_b && !ready_b) |=> valid_b) else $error("Second valid dropped before its ready");

endmodule

bind apb_port axi2apb_assertions u_apb_sva (
    .ACLK(ACLK), .ARESETn(ARESETn), .psel(psel_o), .penable(penable_o),
    .pwrite(pwrite_o), .paddr(paddr_o), .pwdata(pwdata_o), .pready(pready_i),
    .valid_a(psel_o), .ready_a(penable_o && pready_i),
    .valid_b(penable_o), .ready_b(pready_i)
);

bind axi2apb_top axi2apb_assertions u_top_sva (
    .ACLK(ACLK), .ARESETn(ARESETn), .psel(psel_o), .penable(penable_o),
    .pwrite(pwrite_o), .paddr(paddr_o), .pwdata(pwdata_o), .pready(pready_i),
    .valid_a(r_valid_o), .ready_a(r_ready_i), .valid_b(b_valid_o), .ready_b(b_ready_i)
);

// File: tests/axi2apb_tb.sv
/* Directed testbench for the AXI-to-APB bridge with an APB memory model.
   Each test task drives AXI requests and checks responses and APB traffic. */
`timescale 1ns/1ps

module axi2apb_tb import axi2apb_pkg::*; ();

    localparam int TIMEOUT = 200;           // Cycles per wait loop

    logic      ACLK;
    logic      ARESETn;
    logic      ar_valid, ar_ready, aw_valid, aw_ready, w_valid, w_ready;
    axi_id_t   ar_id, aw_id, r_id, b_id;
    axi_addr_t ar_addr, aw_addr;
    axi_size_t ar_size, aw_size;
    axi_data_t w_data, r_data;
    axi_strb_t w_strb;
    axi_resp_t r_resp, b_resp;
    logic      r_valid, r_ready, b_valid, b_ready;
    logic      psel, penable, pwrite, pready, pslverr;
    apb_addr_t paddr;
    apb_data_t pwdata, prdata;

    apb_data_t mem [0:1023];
    logic [1:0] wait_left;
    logic [7:0] wait_rnd;
    logic [31:0] lfsr_q = 32'hc6c4;
    int         xfer_cnt;
    apb_addr_t  addr_log [$];

    tb_clock u_clk (.clk_o(ACLK));

    axi2apb_top UUT (
        .ACLK(ACLK), .ARESETn(ARESETn),
        .ar_valid_i(ar_valid), .ar_id_i(ar_id), .ar_addr_i(ar_addr),
        .ar_size_i(ar_size), .ar_ready_o(ar_ready),
        .aw_valid_i(aw_valid), .aw_id_i(aw_id), .aw_addr_i(aw_addr),
        .aw_size_i(aw_size), .aw_ready_o(aw_ready),
        .w_valid_i(w_valid), .w_data_i(w_data), .w_strb_i(w_strb), .w_ready_o(w_ready),
        .r_id_o(r_id), .r_data_o(r_data), .r_resp_o(r_resp),
        .r_valid_o(r_valid), .r_ready_i(r_ready),
        .b_id_o(b_id), .b_resp_o(b_resp), .b_valid_o(b_valid), .b_ready_i(b_ready),
        .psel_o(psel), .penable_o(penable), .pwrite_o(pwrite), .paddr_o(paddr),
        .pwdata_o(pwdata), .prdata_i(prdata), .pready_i(pready), .pslverr_i(pslverr)
    );

    // ----------------------------------------------------------------------
    // Random source and APB memory model
    // ----------------------------------------------------------------------
    function automatic logic [7:0] rand_bits(input int n);
        logic [7:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_q = {lfsr_q[30:0], lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0]};
            r = {r[6:0], lfsr_q[0]};
        end
        return r;
    endfunction

    function automatic apb_data_t fill_word(input int idx);
        return 32'hA5A50000 | 32'(idx);     // Unique per word address
    endfunction

    assign pready  = penable && (wait_left == 2'd0);
    assign pslverr = penable && (paddr >= 12'h800) && (paddr <= 12'h80F);  // Error window
    assign prdata  = mem[paddr[11:2]];

    always @(posedge ACLK) begin
        if (psel && !penable) begin
            wait_rnd = rand_bits(2);
            wait_left <= wait_rnd[1:0];
        end else if (penable && wait_left != 2'd0) begin
            wait_left <= wait_left - 2'd1;
        end
        if (penable && pready) begin
            xfer_cnt++;
            addr_log.push_back(paddr);
            if (pwrite) mem[paddr[11:2]] <= pwdata;
        end
    end

    // ----------------------------------------------------------------------
    // Reporting and compare tasks
    // ----------------------------------------------------------------------
    task automatic stop_run(input string line);
        $display("%s", line);
        $display("CHECKS FAILED");
        $fatal(1, "Simulation stopped on first error");
    endtask

    task automatic check_data(input axi_data_t got, input axi_data_t exp, input string what);
        if (got !== exp)
            stop_run($sformatf("ERR t=%0t %s: got %h exp %h", $time, what, got, exp));
    endtask

    task automatic check_resp(input axi_resp_t got, input axi_resp_t exp, input string what);
        if (got !== exp)
            stop_run($sformatf("ERR t=%0t %s: got %0d exp %0d", $time, what, got, exp));
    endtask

    task automatic check_id(input axi_id_t got, input axi_id_t exp, input string what);
        if (got !== exp)
            stop_run($sformatf("ERR t=%0t %s: got %0d exp %0d", $time, what, got, exp));
    endtask

    task automatic check_apb_addr(input apb_addr_t got, input apb_addr_t exp, input string what);
        if (got !== exp)
            stop_run($sformatf("ERR t=%0t %s: got %h exp %h", $time, what, got, exp));
    endtask

    task automatic check_count(input int got, input int exp, input string what);
        if (got != exp)
            stop_run($sformatf("ERR t=%0t %s: got %0d exp %0d", $time, what, got, exp));
    endtask

    // ----------------------------------------------------------------------
    // AXI driver tasks
    // ----------------------------------------------------------------------
    task automatic send_write(input axi_id_t id, input axi_addr_t addr, input axi_size_t size,
                              input axi_data_t data, input axi_strb_t strb);
        int t;
        t = 0;
        @(posedge ACLK);
        aw_valid <= 1'b1;
        aw_id    <= id;
        aw_addr  <= addr;
        aw_size  <= size;
        w_valid  <= 1'b1;
        w_data   <= data;
        w_strb   <= strb;
        do begin
            @(negedge ACLK);
            t++;
            if (t > TIMEOUT) stop_run("Timeout: write address and data were never accepted");
        end while (!(aw_ready && w_ready));
        @(posedge ACLK);
        aw_valid <= 1'b0;
        w_valid  <= 1'b0;
    endtask

    task automatic send_read(input axi_id_t id, input axi_addr_t addr, input axi_size_t size);
        int t;
        t = 0;
        @(posedge ACLK);
        ar_valid <= 1'b1;
        ar_id    <= id;
        ar_addr  <= addr;
        ar_size  <= size;
        do begin
            @(negedge ACLK);
            t++;
            if (t > TIMEOUT) stop_run("Timeout: read address was never accepted");
        end while (!ar_ready);
        @(posedge ACLK);
        ar_valid <= 1'b0;
    endtask

    // Holds BREADY low for hold cycles and checks that B stays put meanwhile
    task automatic wait_b(input axi_id_t id, input axi_resp_t resp, input int hold);
        int t;
        t = 0;
        do begin
            @(negedge ACLK);
            t++;
            if (t > TIMEOUT) stop_run("Timeout: no write response arrived");
        end while (!b_valid);
        check_id(b_id, id, "BID");
        check_resp(b_resp, resp, "BRESP");
        repeat (hold) begin
            @(negedge ACLK);
            if (!b_valid) stop_run("BVALID fell before BREADY was given");
            check_id(b_id, id, "BID held");
            check_resp(b_resp, resp, "BRESP held");
            if (ar_ready || aw_ready) stop_run("A new request was accepted while B waited");
        end
        @(posedge ACLK);
        b_ready <= 1'b1;
        @(posedge ACLK);
        b_ready <= 1'b0;
    endtask

    task automatic wait_r(input axi_id_t id, input axi_data_t data, input axi_resp_t resp,
                          input int hold);
        int t;
        t = 0;
        do begin
            @(negedge ACLK);
            t++;
            if (t > TIMEOUT) stop_run("Timeout: no read response arrived");
        end while (!r_valid);
        check_id(r_id, id, "RID");
        check_data(r_data, data, "RDATA");
        check_resp(r_resp, resp, "RRESP");
        repeat (hold) begin
            @(negedge ACLK);
            if (!r_valid) stop_run("RVALID fell before RREADY was given");
            check_id(r_id, id, "RID held");
            check_data(r_data, data, "RDATA held");
            check_resp(r_resp, resp, "RRESP held");
            if (ar_ready || aw_ready) stop_run("A new request was accepted while R waited");
        end
        @(posedge ACLK);
        r_ready <= 1'b1;
        @(posedge ACLK);
        r_ready <= 1'b0;
    endtask

    task automatic clear_log();
        xfer_cnt = 0;
        addr_log.delete();
    endtask

    // ----------------------------------------------------------------------
    // Directed tests
    // ----------------------------------------------------------------------
    task automatic test_dword_rw();
        clear_log();
        send_write(4'd3, 32'h100, SIZE_DWORD, 64'h11223344_55667788, 8'hFF);
        wait_b(4'd3, RESP_OKAY, 0);
        check_count(xfer_cnt, 2, "APB transfers for 64-bit write");
        check_apb_addr(addr_log[0], 12'h100, "low word address");
        check_apb_addr(addr_log[1], 12'h104, "high word address");
        send_read(4'd5, 32'h100, SIZE_DWORD);
        wait_r(4'd5, 64'h11223344_55667788, RESP_OKAY, 0);
    endtask

    task automatic test_word_lanes();
        clear_log();
        send_write(4'd1, 32'h204, 3'd2, 64'hCAFEF00D_0BADBEEF, 8'hF0);
        wait_b(4'd1, RESP_OKAY, 0);
        check_count(xfer_cnt, 1, "APB transfers for 32-bit write");
        check_apb_addr(addr_log[0], 12'h204, "upper lane address");
        clear_log();
        send_read(4'd2, 32'h204, 3'd2);
        wait_r(4'd2, {32'hCAFEF00D, 32'h0}, RESP_OKAY, 0);
        check_count(xfer_cnt, 1, "APB transfers for 32-bit read");
        send_read(4'd4, 32'h200, 3'd2);
        wait_r(4'd4, {32'h0, fill_word(32'h200 >> 2)}, RESP_OKAY, 0);
    endtask

    task automatic test_strobes();
        clear_log();
        send_write(4'd6, 32'h300, SIZE_DWORD, 64'hDEADBEEF_01234567, 8'h0F);
        wait_b(4'd6, RESP_OKAY, 0);
        check_count(xfer_cnt, 1, "APB transfers for low-only strobes");
        send_read(4'd6, 32'h300, SIZE_DWORD);
        wait_r(4'd6, {fill_word(32'h304 >> 2), 32'h01234567}, RESP_OKAY, 0);
        clear_log();
        send_write(4'd7, 32'h310, SIZE_DWORD, 64'h89ABCDEF_76543210, 8'hF0);
        wait_b(4'd7, RESP_OKAY, 0);
        check_count(xfer_cnt, 1, "APB transfers for high-only strobes");
        send_read(4'd7, 32'h310, SIZE_DWORD);
        wait_r(4'd7, {32'h89ABCDEF, fill_word(32'h310 >> 2)}, RESP_OKAY, 0);
    endtask

    task automatic test_slverr();
        send_write(4'd8, 32'h808, SIZE_DWORD, 64'h0, 8'hFF);
        wait_b(4'd8, RESP_SLVERR, 0);
        send_read(4'd9, 32'h800, 3'd2);
        wait_r(4'd9, {32'h0, fill_word(32'h800 >> 2)}, RESP_SLVERR, 0);
        send_read(4'd10, 32'h810, 3'd2);
        wait_r(4'd10, {32'h0, fill_word(32'h810 >> 2)}, RESP_OKAY, 0);
    endtask

    task automatic test_backpressure();
        int hold;
        hold = int'(rand_bits(3)) + 1;
        send_write(4'd11, 32'h400, SIZE_DWORD, 64'h0F1E2D3C_4B5A6978, 8'hFF);
        wait_b(4'd11, RESP_OKAY, hold);
        hold = int'(rand_bits(3)) + 1;
        send_read(4'd12, 32'h400, SIZE_DWORD);
        wait_r(4'd12, 64'h0F1E2D3C_4B5A6978, RESP_OKAY, hold);
    endtask

    task automatic test_arbitration();
        int t;
        t = 0;
        @(posedge ACLK);
        ar_valid <= 1'b1;
        ar_id    <= 4'd13;
        ar_addr  <= 32'h500;
        ar_size  <= SIZE_DWORD;
        aw_valid <= 1'b1;
        aw_id    <= 4'd14;
        aw_addr  <= 32'h508;
        aw_size  <= SIZE_DWORD;
        w_valid  <= 1'b1;
        w_data   <= 64'h13579BDF_2468ACE0;
        w_strb   <= 8'hFF;
        @(negedge ACLK);
        if (!ar_ready || aw_ready) stop_run("Read did not win over the pending write");
        @(posedge ACLK);
        ar_valid <= 1'b0;
        wait_r(4'd13, {fill_word(32'h504 >> 2), fill_word(32'h500 >> 2)}, RESP_OKAY, 1);
        // Pending write stays valid and is taken once the read is done
        do begin
            @(negedge ACLK);
            t++;
            if (t > TIMEOUT) stop_run("Timeout: pending write was not accepted after the read");
        end while (!(aw_ready && w_ready));
        @(posedge ACLK);
        aw_valid <= 1'b0;
        w_valid  <= 1'b0;
        wait_b(4'd14, RESP_OKAY, 0);
        // Lone AW must wait for W
        @(posedge ACLK);
        aw_valid <= 1'b1;
        aw_id    <= 4'd15;
        aw_addr  <= 32'h510;
        aw_size  <= 3'd2;
        repeat (4) begin
            @(negedge ACLK);
            if (aw_ready) stop_run("AW was accepted without W");
        end
        send_write(4'd15, 32'h510, 3'd2, 64'h0000_0000_600DCAFE, 8'h0F);
        wait_b(4'd15, RESP_OKAY, 0);
        send_read(4'd1, 32'h508, SIZE_DWORD);
        wait_r(4'd1, 64'h13579BDF_2468ACE0, RESP_OKAY, 0);
        send_read(4'd2, 32'h510, 3'd2);
        wait_r(4'd2, {32'h0, 32'h600DCAFE}, RESP_OKAY, 0);
    endtask

    // ----------------------------------------------------------------------
    // Main sequence
    // ----------------------------------------------------------------------
    initial begin
        for (int i = 0; i < 1024; i++) begin
            mem[i] <= fill_word(i);
        end
        wait_left <= 2'd0;
        xfer_cnt  = 0;
        ARESETn  <= 1'b0;
        ar_valid <= 1'b0;
        ar_id    <= '0;
        ar_addr  <= '0;
        ar_size  <= '0;
        aw_valid <= 1'b0;
        aw_id    <= '0;
        aw_addr  <= '0;
        aw_size  <= '0;
        w_valid  <= 1'b0;
        w_data   <= '0;
        w_strb   <= '0;
        r_ready  <= 1'b0;
        b_ready  <= 1'b0;
        repeat (3) @(posedge ACLK);
        ARESETn <= 1'b1;
        test_dword_rw();
        test_word_lanes();
        test_strobes();
        test_slverr();
        test_backpressure();
        test_arbitration();
        repeat (2) @(posedge ACLK);
        $display("ALL CHECKS PASSED");
        $finish;
    end

endmodule

// File: files.f
rtl/axi2apb_pkg.sv
rtl/axi_req_latch.sv
rtl/bridge_ctrl.sv
rtl/apb_port.sv
rtl/rdata_collect.sv
rtl/axi2apb_top.sv
tests/tb_clock.sv
tests/axi2apb_assertions.sv
tests/axi2apb_tb.sv

// File: run.sh
#!/usr/bin/env bash
# Build and run the bridge testbench with Verilator, then scan the log
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module axi2apb_tb -f files.f -o axi2apb_sim \
    || { echo "Build failed"; exit 1; }

./obj_dir/axi2apb_sim > sim.log 2>&1
cat sim.log

! grep -q "CHECKS FAILED" sim.log && grep -q "ALL CHECKS PASSED" sim.log \
    && echo "Simulation passed" \
    || { echo "Simulation failed"; exit 1; }
